//--- src/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Data path word width
`define MEM_DATA_W 32

// Power-of-two memory size in bytes so addresses wrap
`define MEM_SIZE 1024

`define MEM_ADDR_W $clog2(`MEM_SIZE)  // Byte address width

`define MEM_REG_W 5                   // Write-back register index width

`endif

//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Number of bytes moved by one load or store.
    // Bit 1 drops the upper half, bit 0 drops one more byte
    typedef enum logic [1:0] {
        SIZE_WORD = 2'b00,  // 4 bytes
        SIZE_TRI  = 2'b01,  // 3 bytes
        SIZE_HALF = 2'b10,  // 2 bytes
        SIZE_BYTE = 2'b11   // 1 byte
    } access_size_e;

endpackage

`default_nettype wire

//--- src/mem_stage_ctrl.sv
`default_nettype none
`include "mem_settings.svh"

module mem_stage_ctrl
    import mem_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,

    // Handshake
    input  wire logic                   i_valid,
    output logic                        o_ready,
    output logic                        o_valid,
    input  wire logic                   i_ready,

    // Request from execute
    input  wire logic                   i_mem_read,
    input  wire logic                   i_mem_write,
    input  wire access_size_e           i_size,
    input  wire logic                   i_unsigned,
    input  wire logic [`MEM_DATA_W-1:0] i_alu_result,
    input  wire logic                   i_branch,
    input  wire logic                   i_zero,
    input  wire logic                   i_reg_write,
    input  wire logic [`MEM_REG_W-1:0]  i_wb_reg,

    // Memory strobes
    output logic                        o_ram_rd_en,
    output logic                        o_ram_wr_en,

    // Held fields for the load formatter
    output access_size_e                o_hold_size,
    output logic                        o_hold_unsigned,
    output logic                        o_hold_load,

    // Stage outputs
    output logic [`MEM_DATA_W-1:0]      o_alu_result,
    output logic                        o_pc_source,
    output logic                        o_reg_write,
    output logic [`MEM_REG_W-1:0]       o_wb_reg
);

    logic accept;

    // Room when empty or when the held item leaves on this edge
    assign o_ready = !o_valid || i_ready;
    assign accept  = i_valid && o_ready;

    // The memory only moves on an accepted request
    assign o_ram_rd_en = accept && i_mem_read;
    assign o_ram_wr_en = accept && i_mem_write;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid     <= 1'b0;
            o_pc_source <= 1'b0;
            o_reg_write <= 1'b0;
            o_hold_load <= 1'b0;
        end else if (accept) begin
            o_valid     <= 1'b1;
            o_pc_source <= i_branch & i_zero;  // Branch taken
            o_reg_write <= i_reg_write;
            o_hold_load <= i_mem_read;
        end else if (i_ready) begin
            o_valid     <= 1'b0;               // Item left, nothing new
        end
    end

    // Payload fields of the accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            o_alu_result    <= i_alu_result;
            o_wb_reg        <= i_wb_reg;
            o_hold_size     <= i_size;
            o_hold_unsigned <= i_unsigned;
        end
    end

endmodule

`default_nettype wire

//--- src/data_ram.sv
`default_nettype none
`include "mem_settings.svh"

module data_ram
    import mem_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   i_rd_en,
    input  wire logic                   i_wr_en,
    input  wire access_size_e           i_size,
    input  wire logic [`MEM_ADDR_W-1:0] i_addr,
    input  wire logic [`MEM_DATA_W-1:0] i_wdata,
    output logic [`MEM_DATA_W-1:0]      o_rdata,
    input  wire logic [`MEM_ADDR_W-1:0] i_debug_addr,
    output logic [`MEM_DATA_W-1:0]      o_debug_data
);

    logic [7:0]             mem [`MEM_SIZE];  // Byte array, little endian
    logic [`MEM_ADDR_W-1:0] lane_addr [4];
    logic [`MEM_ADDR_W-1:0] dbg_addr [4];
    logic [3:0]             lane_en;

    // Address arithmetic stays in the address width, so it wraps
    function automatic logic [`MEM_ADDR_W-1:0] wrap_add(
        input logic [`MEM_ADDR_W-1:0] base,
        input logic [1:0]             off
    );
        wrap_add = base + {{(`MEM_ADDR_W-2){1'b0}}, off};
    endfunction

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            lane_addr[b] = wrap_add(i_addr, 2'(b));
            dbg_addr[b]  = wrap_add(i_debug_addr, 2'(b));
        end
    end

    always_comb begin
        case (i_size)
            SIZE_WORD: lane_en = 4'b1111;
            SIZE_TRI:  lane_en = 4'b0111;
            SIZE_HALF: lane_en = 4'b0011;
            default:   lane_en = 4'b0001;  // Single byte
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MEM_SIZE; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (i_wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    mem[lane_addr[b]] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

    // Always the full word; the formatter trims it
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rdata <= {mem[lane_addr[3]], mem[lane_addr[2]],
                        mem[lane_addr[1]], mem[lane_addr[0]]};
        end
    end

    always_ff @(posedge clk) begin
        o_debug_data <= {mem[dbg_addr[3]], mem[dbg_addr[2]],
                         mem[dbg_addr[1]], mem[dbg_addr[0]]};
    end

endmodule

`default_nettype wire

//--- src/load_format.sv
`default_nettype none
`include "mem_settings.svh"

module load_format
    import mem_pkg::*;
(
    input  wire logic [`MEM_DATA_W-1:0] i_raw,
    input  wire access_size_e           i_size,
    input  wire logic                   i_unsigned,
    input  wire logic                   i_load,
    input  wire logic [`MEM_DATA_W-1:0] i_alu_result,
    output logic [`MEM_DATA_W-1:0]      o_data
);

    logic [`MEM_DATA_W-1:0] ext;
    logic                   fill;

    always_comb begin
        case (i_size)
            SIZE_WORD: begin
                fill = 1'b0;
                ext  = i_raw;                       // Passed through as is
            end
            SIZE_TRI: begin
                fill = !i_unsigned && i_raw[23];
                ext  = {{8{fill}}, i_raw[23:0]};
            end
            SIZE_HALF: begin
                fill = !i_unsigned && i_raw[15];
                ext  = {{16{fill}}, i_raw[15:0]};
            end
            default: begin
                fill = !i_unsigned && i_raw[7];
                ext  = {{24{fill}}, i_raw[7:0]};
            end
        endcase
    end

    // Non-load items carry the ALU result
    assign o_data = i_load ? ext : i_alu_result;

endmodule

`default_nettype wire

//--- src/mem_stage.sv
`default_nettype none
`include "mem_settings.svh"

module mem_stage
    import mem_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,

    // From execute
    input  wire logic                   i_valid,
    output logic                        o_ready,
    input  wire logic                   i_mem_read,
    input  wire logic                   i_mem_write,
    input  wire access_size_e           i_size,
    input  wire logic                   i_unsigned,
    input  wire logic [`MEM_ADDR_W-1:0] i_addr,
    input  wire logic [`MEM_DATA_W-1:0] i_wdata,
    input  wire logic [`MEM_DATA_W-1:0] i_alu_result,
    input  wire logic                   i_branch,
    input  wire logic                   i_zero,
    input  wire logic                   i_reg_write,
    input  wire logic [`MEM_REG_W-1:0]  i_wb_reg,

    // To write-back
    output logic                        o_valid,
    input  wire logic                   i_ready,
    output logic [`MEM_DATA_W-1:0]      o_rdata,
    output logic                        o_pc_source,
    output logic                        o_reg_write,
    output logic [`MEM_REG_W-1:0]       o_wb_reg,

    // Debug read port
    input  wire logic [`MEM_ADDR_W-1:0] i_debug_addr,
    output logic [`MEM_DATA_W-1:0]      o_debug_data
);

    logic                   ram_rd_en;
    logic                   ram_wr_en;
    logic [`MEM_DATA_W-1:0] ram_rdata;
    access_size_e           hold_size;
    logic                   hold_unsigned;
    logic                   hold_load;
    logic [`MEM_DATA_W-1:0] hold_alu_result;

    mem_stage_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .i_valid         (i_valid),
        .o_ready         (o_ready),
        .o_valid         (o_valid),
        .i_ready         (i_ready),
        .i_mem_read      (i_mem_read),
        .i_mem_write     (i_mem_write),
        .i_size          (i_size),
        .i_unsigned      (i_unsigned),
        .i_alu_result    (i_alu_result),
        .i_branch        (i_branch),
        .i_zero          (i_zero),
        .i_reg_write     (i_reg_write),
        .i_wb_reg        (i_wb_reg),
        .o_ram_rd_en     (ram_rd_en),
        .o_ram_wr_en     (ram_wr_en),
        .o_hold_size     (hold_size),
        .o_hold_unsigned (hold_unsigned),
        .o_hold_load     (hold_load),
        .o_alu_result    (hold_alu_result),
        .o_pc_source     (o_pc_source),
        .o_reg_write     (o_reg_write),
        .o_wb_reg        (o_wb_reg)
    );

    // Address, data and size go straight in; strobes come from ctrl
    data_ram u_ram (
        .clk          (clk),
        .rst          (rst),
        .i_rd_en      (ram_rd_en),
        .i_wr_en      (ram_wr_en),
        .i_size       (i_size),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .o_rdata      (ram_rdata),
        .i_debug_addr (i_debug_addr),
        .o_debug_data (o_debug_data)
    );

    load_format u_fmt (
        .i_raw        (ram_rdata),
        .i_size       (hold_size),
        .i_unsigned   (hold_unsigned),
        .i_load       (hold_load),
        .i_alu_result (hold_alu_result),
        .o_data       (o_rdata)
    );

endmodule

`default_nettype wire

//--- bench/mem_checker.sv
`default_nettype none
`include "mem_settings.svh"

module mem_checker
    import mem_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   i_in_valid, i_in_ready, i_out_valid, i_out_ready,
    input  wire logic                   i_mem_read, i_mem_write, i_unsigned,
    input  wire logic                   i_branch, i_zero, i_reg_write,
    input  wire access_size_e           i_size,
    input  wire logic [`MEM_ADDR_W-1:0] i_addr, i_debug_addr,
    input  wire logic [`MEM_DATA_W-1:0] i_wdata, i_alu_result,
    input  wire logic [`MEM_REG_W-1:0]  i_wb_reg,
    input  wire logic [`MEM_DATA_W-1:0] i_rdata, i_debug_data,
    input  wire logic                   i_pc_source, i_out_reg_write,
    input  wire logic [`MEM_REG_W-1:0]  i_out_wb_reg,
    output int                          o_errors,
    output int                          o_pending
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW    = `MEM_DATA_W;
    localparam int AW    = `MEM_ADDR_W;
    localparam int OUT_W = DW + `MEM_REG_W + 2;  // {pc_source, reg_write, wb_reg, data}

    logic [7:0]       model [`MEM_SIZE];  // Reference bytes, little endian
    logic [OUT_W-1:0] expect_q [$];       // Accepted items not yet out
    logic [OUT_W-1:0] expected;
    logic [OUT_W-1:0] seen;
    logic [OUT_W-1:0] held;               // Outputs at the last stalled edge
    logic [DW-1:0]    result;
    logic [DW-1:0]    dbg_expect;
    logic [AW-1:0]    store_addr;
    logic             dbg_pending = 1'b0;
    logic             stalled = 1'b0;
    int               data_errs = 0;
    int               flow_errs = 0;
    int               debug_errs = 0;

    function automatic int size_bytes(input access_size_e size);
        case (size)
            SIZE_WORD: return 4;
            SIZE_TRI:  return 3;
            SIZE_HALF: return 2;
            default:   return 1;
        endcase
    endfunction

    // Low n bytes from addr upward, zero or sign filled above
    function automatic logic [DW-1:0] model_word(input logic [AW-1:0] addr, input int n,
                                                 input logic sign);
        logic [DW-1:0] word;
        logic [AW-1:0] a;
        word = '0;
        for (int b = 0; b < n; b++) begin
            a    = addr + AW'(b);  // Wraps at the memory size
            word = word | (DW'(model[a]) << (8 * b));
        end
        if (sign && n < 4 && ((word >> (8 * n - 1)) & 1) != 0)
            word = word | ({DW{1'b1}} << (8 * n));
        return word;
    endfunction

    function automatic bit mismatch(input string name, input logic [DW-1:0] exp_val,
                                    input logic [DW-1:0] act_val);
        if (exp_val === act_val)
            return 1'b0;
        $display("CHECK FAILED %s: expected %h, actual %h at %0t", name, exp_val, act_val, $time);
        return 1'b1;
    endfunction

    task automatic print_counts();
        $display("Errors: %0d data, %0d flow, %0d debug; %0d items still outstanding",
                 data_errs, flow_errs, debug_errs, expect_q.size());
    endtask

    // Mid-cycle sampling sees what the next rising edge will act on
    always @(negedge clk) begin
        if (rst) begin
            flow_errs += int'(mismatch("reset outputs", '0,
                                       DW'({i_out_valid, i_pc_source, i_out_reg_write})));
            model = '{default: 8'h00};
            expect_q.delete();
            dbg_pending = 1'b0;
            stalled     = 1'b0;
        end else begin
            if (dbg_pending)
                debug_errs += int'(mismatch("debug read", dbg_expect, i_debug_data));
            dbg_expect  = model_word(i_debug_addr, 4, 1'b0);  // Before this edge's store
            dbg_pending = 1'b1;

            seen = {i_pc_source, i_out_reg_write, i_out_wb_reg, i_rdata};
            if (stalled) begin
                flow_errs += int'(mismatch("stall valid", DW'(1'b1), DW'(i_out_valid)));
                flow_errs += int'(mismatch("stall data", held[DW-1:0], i_rdata));
                flow_errs += int'(mismatch("stall ctrl", DW'(held[OUT_W-1:DW]),
                                           DW'(seen[OUT_W-1:DW])));
            end
            stalled = i_out_valid && !i_out_ready;
            held    = seen;

            // One-item stage: valid one cycle after acceptance, ready when empty or leaving
            flow_errs += int'(mismatch("out valid", DW'(expect_q.size() != 0),
                                       DW'(i_out_valid)));
            flow_errs += int'(mismatch("in ready", DW'(expect_q.size() == 0 || i_out_ready),
                                       DW'(i_in_ready)));

            if (i_out_valid && i_out_ready) begin
                if (expect_q.size() == 0) begin
                    $display("Output transfer at %0t with no accepted request behind it", $time);
                    flow_errs++;
                end else begin
                    expected = expect_q.pop_front();
                    data_errs += int'(mismatch("rdata", expected[DW-1:0], i_rdata));
                    data_errs += int'(mismatch("wb_reg", DW'(expected[DW +: `MEM_REG_W]),
                                               DW'(i_out_wb_reg)));
                    data_errs += int'(mismatch("reg_write", DW'(expected[OUT_W-2]),
                                               DW'(i_out_reg_write)));
                    data_errs += int'(mismatch("pc_source", DW'(expected[OUT_W-1]),
                                               DW'(i_pc_source)));
                end
            end

            if (i_in_valid && i_in_ready) begin
                if (i_mem_read)
                    result = model_word(i_addr, size_bytes(i_size), !i_unsigned);
                else
                    result = i_alu_result;
                expect_q.push_back({i_branch & i_zero, i_reg_write, i_wb_reg, result});
                if (i_mem_write) begin
                    for (int b = 0; b < size_bytes(i_size); b++) begin
                        store_addr        = i_addr + AW'(b);
                        model[store_addr] = 8'(i_wdata >> (8 * b));
                    end
                end
            end
        end
        o_pending = expect_q.size();
        o_errors  = data_errs + flow_errs + debug_errs;
    end

endmodule

`default_nettype wire

//--- bench/tb_mem_stage.sv
`default_nettype none
`include "mem_settings.svh"

module tb_mem_stage
    import mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW      = `MEM_ADDR_W;
    localparam int NUM_REQ = 400;
    localparam int TIMEOUT = 40;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   i_valid, o_ready, o_valid, i_ready;
    logic                   i_mem_read, i_mem_write, i_unsigned;
    access_size_e           i_size;
    logic [AW-1:0]          i_addr, i_debug_addr;
    logic [`MEM_DATA_W-1:0] i_wdata, i_alu_result, o_rdata, o_debug_data;
    logic                   i_branch, i_zero, i_reg_write, o_pc_source, o_reg_write;
    logic [`MEM_REG_W-1:0]  i_wb_reg, o_wb_reg;
    logic [AW-1:0]          last_store;  // Debug port revisits this now and then
    logic                   ok;
    int                     chk_errors;
    int                     chk_pending;

    always #10 clk = ~clk;

    mem_stage uut (.*);

    mem_checker chk (
        .clk             (clk),
        .rst             (rst),
        .i_in_valid      (i_valid),
        .i_in_ready      (o_ready),
        .i_out_valid     (o_valid),
        .i_out_ready     (i_ready),
        .i_mem_read      (i_mem_read),
        .i_mem_write     (i_mem_write),
        .i_unsigned      (i_unsigned),
        .i_branch        (i_branch),
        .i_zero          (i_zero),
        .i_reg_write     (i_reg_write),
        .i_size          (i_size),
        .i_addr          (i_addr),
        .i_debug_addr    (i_debug_addr),
        .i_wdata         (i_wdata),
        .i_alu_result    (i_alu_result),
        .i_wb_reg        (i_wb_reg),
        .i_rdata         (o_rdata),
        .i_debug_data    (o_debug_data),
        .i_pc_source     (o_pc_source),
        .i_out_reg_write (o_reg_write),
        .i_out_wb_reg    (o_wb_reg),
        .o_errors        (chk_errors),
        .o_pending       (chk_pending)
    );

    // Mostly a small busy region so loads hit earlier stores
    function automatic logic [AW-1:0] pick_addr();
        logic [31:0] word;
        word = $urandom;
        case (word[1:0])
            2'd0:    pick_addr = AW'(`MEM_SIZE - 4) + AW'(word[3:2]);  // Wraps past the top
            2'd1:    pick_addr = word[AW+1:2];
            default: pick_addr = AW'(word[7:2]);
        endcase
    endfunction

    // One rising edge, with new back-pressure and a new debug address
    task automatic next_edge();
        logic [31:0] word;
        @(posedge clk);
        word = $urandom;
        i_ready <= ($urandom_range(3) != 0);
        if (word[31])
            i_debug_addr <= last_store;
        else
            i_debug_addr <= word[AW-1:0];
    endtask

    task automatic send_request(output logic done);
        logic [31:0]   word;
        logic [AW-1:0] addr;
        int            kind;
        int            waited;
        word = $urandom;
        kind = $urandom_range(2);  // 0 store, 1 load, 2 ALU or branch
        addr = pick_addr();
        if (kind == 0)
            last_store = addr;
        i_valid      <= 1'b1;
        i_mem_write  <= (kind == 0);
        i_mem_read   <= (kind == 1);
        i_size       <= access_size_e'(word[1:0]);
        i_unsigned   <= word[2];
        i_branch     <= word[3];
        i_zero       <= word[4];
        i_reg_write  <= word[5];
        i_wb_reg     <= word[6 +: `MEM_REG_W];
        i_addr       <= addr;
        i_wdata      <= $urandom;
        i_alu_result <= $urandom;
        for (waited = 0; waited < TIMEOUT; waited++) begin
            @(negedge clk);
            if (o_ready)
                break;
            next_edge();
        end
        done = (waited < TIMEOUT);
        if (done)
            next_edge();  // The transfer edge
        else
            $display("Stall: o_ready stayed low for %0d cycles with a request waiting", TIMEOUT);
    endtask

    task automatic drain(output logic done);
        int waited;
        i_valid <= 1'b0;
        for (waited = 0; waited < TIMEOUT; waited++) begin
            next_edge();
            if (chk_pending == 0)
                break;
        end
        done = (waited < TIMEOUT);
        if (!done)
            $display("Stall: %0d items never left the stage", chk_pending);
    endtask

    initial begin
        void'($urandom(32'ha0f8));
        ok           = 1'b1;
        last_store   = '0;
        rst          <= 1'b1;
        i_valid      <= 1'b0;
        i_ready      <= 1'b0;
        i_mem_read   <= 1'b0;
        i_mem_write  <= 1'b0;
        i_size       <= SIZE_WORD;
        i_unsigned   <= 1'b0;
        i_addr       <= '0;
        i_wdata      <= '0;
        i_alu_result <= '0;
        i_branch     <= 1'b0;
        i_zero       <= 1'b0;
        i_reg_write  <= 1'b0;
        i_wb_reg     <= '0;
        i_debug_addr <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (8) next_edge();  // Debug reads of the cleared memory

        for (int n = 0; n < NUM_REQ && ok; n++) begin
            if ($urandom_range(3) == 0) begin
                i_valid <= 1'b0;  // Upstream bubble
                next_edge();
            end
            send_request(ok);
        end
        if (ok)
            drain(ok);
        repeat (2) next_edge();

        chk.print_counts();
        if (ok && chk_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+src
src/mem_pkg.sv
src/mem_stage_ctrl.sv
src/data_ram.sv
src/load_format.sv
src/mem_stage.sv
bench/mem_checker.sv
bench/tb_mem_stage.sv

//--- run.sh
#!/bin/sh
# Build and run the mem_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f filelist.f --top-module tb_mem_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mem_stage)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
